// File: flist.f
+incdir+.
exu_pkg.sv
exu_pipeline.sv
exu_regfile.sv
exu_alu.sv
exu_control.sv
exu_top.sv
exu_tb.sv

// File: run.sh
#!/bin/sh
# Builds the exu testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module exu_tb \
    -f flist.f -o exu_sim
if [ $? -ne 0 ]; then
    echo "run.sh: Verilator build failed"
    exit 1
fi

./obj_dir/exu_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "run.sh: simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
    echo "run.sh: PASS"
    exit 0
fi
echo "run.sh: FAIL"
exit 1

// File: exu_tb.sv
// Testbench for exu_top. Stimulus is fixed by the LFSR seed; the model
// assumes results reach each register in issue order.

`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int DW           = `EXU_DATA_W;
    localparam int RW           = `EXU_REG_W;
    localparam int SEED_NB      = 7;
    localparam int INDEP_NB     = 200;
    localparam int DEP_NB       = 300;
    localparam int STALL_BOUND  = 8 * (`EXU_STAGES + 4);
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + 50 + (SEED_NB + 1 + INDEP_NB + DEP_NB) * STALL_BOUND;
    localparam int MODE_SEED    = 0;
    localparam int MODE_INDEP   = 1;
    localparam int MODE_DEP     = 2;

    logic            aclk;
    logic            aresetn;
    logic            i_instr_valid;
    exu_pkg::instr_t i_instr;
    logic            o_instr_ready;
    logic            o_wb_valid;
    exu_pkg::wb_t    o_wb;
    logic            i_wb_ready;

    logic [31:0]     lfsr_state = 32'h4adf_9035;
    logic [DW-1:0]   model_regs [`EXU_REG_NB];
    exu_pkg::wb_t    exp_q [$];
    exu_pkg::instr_t cur_instr;
    exu_pkg::wb_t    held_wb;
    logic            hold_valid;
    logic            wb_held;
    logic            accepted;
    int              gen_count;
    int              issued;
    int              wb_count;
    int              cycle_count;
    int              accept_cycle;
    int              last_wb_cycle;

    exu_top uut (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_instr_ready (o_instr_ready),
        .o_wb_valid    (o_wb_valid),
        .o_wb          (o_wb),
        .i_wb_ready    (i_wb_ready)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        abort_run("Timeout: the run took longer than its worst-case bound.");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_wb(input string name, input exu_pkg::wb_t got,
                            input exu_pkg::wb_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s: got rd=%h data=%h, expected rd=%h data=%h",
                                name, got.rd, got.data, exp.rd, exp.data));
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("ERR %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [DW-1:0] alu_model(input exu_pkg::instr_t ins,
                                                input logic [DW-1:0] a,
                                                input logic [DW-1:0] r2);
        logic [DW-1:0] b;
        logic [DW-1:0] msb;
        int            sh;
        b   = ins.use_imm ? ins.imm : r2;
        sh  = int'(b[4:0]);
        msb = DW'(1) << (DW - 1);
        case (ins.op)
            exu_pkg::OP_ADD:  return a + b;
            exu_pkg::OP_SUB:  return a + ~b + DW'(1);
            exu_pkg::OP_AND:  return a & b;
            exu_pkg::OP_OR:   return a | b;
            exu_pkg::OP_XOR:  return a ^ b;
            exu_pkg::OP_SLL:  return a << sh;
            exu_pkg::OP_SRL:  return a >> sh;
            // Logical shift, then fill the vacated top bits with the sign.
            exu_pkg::OP_SRA:  return (a >> sh) | ((a & msb) != '0 ? ~({DW{1'b1}} >> sh) : '0);
            // Flipping the sign bits turns a signed compare into an unsigned one.
            exu_pkg::OP_SLT:  return DW'((a ^ msb) < (b ^ msb));
            exu_pkg::OP_SLTU: return DW'(a < b);
            exu_pkg::OP_LUI:  return ins.imm;
            default:          return '0;
        endcase
    endfunction

    function automatic exu_pkg::instr_t gen_instr(input int mode);
        exu_pkg::instr_t ins;
        ins.use_imm = rand_bits(1) != 32'd0;
        ins.imm     = DW'(rand_bits(32));
        case (mode)
            MODE_SEED: begin
                ins.op  = exu_pkg::OP_LUI;
                ins.rd  = RW'((gen_count % SEED_NB) + 1);
                ins.rs1 = '0;
                ins.rs2 = '0;
            end
            MODE_INDEP: begin
                // Sources in x0..x7, results in x8..x15.
                ins.op  = exu_pkg::alu_op_t'(4'(gen_count % 11));
                ins.rs1 = RW'(rand_bits(3));
                ins.rs2 = RW'(rand_bits(3));
                ins.rd  = RW'(rand_bits(3) + 8);
            end
            default: begin
                // x0..x3 only, so most instructions depend on recent ones.
                ins.op  = exu_pkg::alu_op_t'(4'(rand_bits(4) % 11));
                ins.rs1 = RW'(rand_bits(2));
                ins.rs2 = RW'(rand_bits(2));
                ins.rd  = RW'(rand_bits(2));
            end
        endcase
        gen_count++;
        return ins;
    endfunction

    function automatic exu_pkg::wb_t model_issue(input exu_pkg::instr_t ins);
        exu_pkg::wb_t r;
        r.rd   = ins.rd;
        r.data = alu_model(ins, model_regs[ins.rs1], model_regs[ins.rs2]);
        if (ins.rd != '0) begin
            model_regs[ins.rd] = r.data;
        end
        return r;
    endfunction

    // Drive at the falling edge, then judge the handshakes of the next rising edge.
    task automatic step_cycle(input logic want_new, input int mode, input logic bp);
        @(negedge aclk);
        if (!hold_valid && want_new) begin
            cur_instr  = gen_instr(mode);
            hold_valid = 1'b1;
        end
        i_instr_valid = hold_valid;
        i_instr       = cur_instr;
        i_wb_ready    = bp ? (rand_bits(2) != 32'd0) : 1'b1;
        #1;
        accepted = 1'b0;
        if (hold_valid && o_instr_ready) begin
            exp_q.push_back(model_issue(cur_instr));
            hold_valid   = 1'b0;
            accepted     = 1'b1;
            accept_cycle = cycle_count;
            issued++;
        end
        if (o_wb_valid) begin
            if (wb_held) begin
                check_wb("o_wb while held", o_wb, held_wb);
            end
            if (exp_q.size() == 0) begin
                abort_run("o_wb_valid was raised with no result outstanding.");
            end
            check_wb("o_wb", o_wb, exp_q[0]);
            wb_held = !i_wb_ready;
            held_wb = o_wb;
            if (i_wb_ready) begin
                void'(exp_q.pop_front());
                wb_count++;
                last_wb_cycle = cycle_count;
            end
        end else if (wb_held) begin
            abort_run("o_wb_valid dropped before the result was taken.");
        end
        cycle_count++;
    endtask

    task automatic issue_stream(input int count, input int mode, input logic bp);
        int start;
        start = issued;
        while (issued - start < count) begin
            step_cycle(bp ? (rand_bits(3) != 32'd0) : 1'b1, mode, bp);
        end
    endtask

    task automatic drain(input logic bp);
        while (exp_q.size() != 0) begin
            step_cycle(1'b0, MODE_DEP, bp);
        end
        // Nothing more may appear once the queue is empty.
        repeat (`EXU_STAGES + 3) step_cycle(1'b0, MODE_DEP, bp);
    endtask

    task automatic measure_latency();
        int start_wb;
        start_wb = wb_count;
        accepted = 1'b0;
        while (!accepted) begin
            step_cycle(1'b1, MODE_DEP, 1'b0);
        end
        while (wb_count == start_wb) begin
            step_cycle(1'b0, MODE_DEP, 1'b0);
        end
        check_count("writeback latency", last_wb_cycle - accept_cycle, `EXU_STAGES);
    endtask

    initial begin
        aresetn       = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        i_wb_ready    = 1'b0;
        cur_instr     = '0;
        held_wb       = '0;
        hold_valid    = 1'b0;
        wb_held       = 1'b0;
        accepted      = 1'b0;
        gen_count     = 0;
        issued        = 0;
        wb_count      = 0;
        cycle_count   = 0;
        accept_cycle  = 0;
        last_wb_cycle = 0;
        for (int r = 0; r < `EXU_REG_NB; r++) begin
            model_regs[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        #1;
        check_ready("o_wb_valid", o_wb_valid, 1'b0);
        check_ready("o_instr_ready", o_instr_ready, 1'b1);
        issue_stream(SEED_NB, MODE_SEED, 1'b0);
        drain(1'b0);
        measure_latency();
        issue_stream(INDEP_NB, MODE_INDEP, 1'b1);
        issue_stream(DEP_NB, MODE_DEP, 1'b1);
        drain(1'b1);
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: exu_top.sv
// Execution unit top. Results leave in issue order per register; o_wb
// holds steady while i_wb_ready is low.

`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_top (
    input  wire                         aclk,
    input  wire                         aresetn,
    input  wire                         i_instr_valid,
    input  wire  exu_pkg::instr_t       i_instr,
    output logic                        o_instr_ready,
    output logic                        o_wb_valid,
    output exu_pkg::wb_t                o_wb,
    input  wire                         i_wb_ready
);

    logic [`EXU_DATA_W-1:0] rs1_data;
    logic [`EXU_DATA_W-1:0] rs2_data;
    exu_pkg::wb_t           alu_result;
    logic                   pipe_valid;
    logic                   pipe_ready;
    logic                   we;

    exu_control u_control (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_instr_ready (o_instr_ready),
        .o_pipe_valid  (pipe_valid),
        .i_pipe_ready  (pipe_ready),
        .i_wb_valid    (o_wb_valid),
        .i_wb_ready    (i_wb_ready),
        .i_wb_rd       (o_wb.rd),
        .o_we          (we)
    );

    exu_regfile u_regfile (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_rs1      (i_instr.rs1),
        .i_rs2      (i_instr.rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_we       (we),
        .i_wb       (o_wb)
    );

    exu_alu u_alu (
        .i_instr    (i_instr),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_result   (alu_result)
    );

    exu_pipeline #(
        .DATA_BUS_W  ($bits(exu_pkg::wb_t)),
        .NB_PIPELINE (`EXU_STAGES)
    ) u_pipeline (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_valid (pipe_valid),
        .o_ready (pipe_ready),
        .i_data  (alu_result),
        .o_valid (o_wb_valid),
        .i_ready (i_wb_ready),
        .o_data  (o_wb)
    );

endmodule

`default_nettype wire

// File: exu_control.sv
// Issue control. A source or destination with a write in flight stalls issue,
// so each register sees its results in program order. No forwarding.

`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_control (
    input  wire                         aclk,
    input  wire                         aresetn,
    input  wire                         i_instr_valid,
    input  wire  exu_pkg::instr_t       i_instr,
    output logic                        o_instr_ready,
    output logic                        o_pipe_valid,
    input  wire                         i_pipe_ready,
    input  wire                         i_wb_valid,
    input  wire                         i_wb_ready,
    input  wire  [`EXU_REG_W-1:0]       i_wb_rd,
    output logic                        o_we
);

    // One bit per register with a result still in the pipeline.
    logic [`EXU_REG_NB-1:0] pending;
    logic [`EXU_REG_NB-1:0] set_mask;
    logic [`EXU_REG_NB-1:0] clr_mask;
    logic                   hazard;
    logic                   issue;

    // x0 never blocks.
    always_comb begin
        hazard = 1'b0;
        if (i_instr.rs1 != '0 && pending[i_instr.rs1]) begin
            hazard = 1'b1;
        end
        if (i_instr.rs2 != '0 && pending[i_instr.rs2]) begin
            hazard = 1'b1;
        end
        if (i_instr.rd != '0 && pending[i_instr.rd]) begin
            hazard = 1'b1;
        end
    end

    assign o_instr_ready = i_pipe_ready & ~hazard;
    assign o_pipe_valid  = i_instr_valid & ~hazard;
    assign issue         = i_instr_valid & o_instr_ready;

    // Writeback handshake drives the register write.
    assign o_we = i_wb_valid & i_wb_ready;

    always_comb begin
        set_mask = '0;
        if (issue && i_instr.rd != '0) begin
            set_mask[i_instr.rd] = 1'b1;
        end
    end

    always_comb begin
        clr_mask = '0;
        if (o_we) begin
            clr_mask[i_wb_rd] = 1'b1;
        end
    end

    // Set wins over a clear of the same rd.
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clr_mask) | set_mask;
        end
    end

endmodule

`default_nettype wire

// File: exu_alu.sv
// Combinational integer ALU. Shift amounts use the low 5 bits of the
// second operand, so EXU_DATA_W is expected to be 32.

`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_alu (
    input  wire  exu_pkg::instr_t       i_instr,
    input  wire  [`EXU_DATA_W-1:0]      i_rs1_data,
    input  wire  [`EXU_DATA_W-1:0]      i_rs2_data,
    output exu_pkg::wb_t                o_result
);

    logic [`EXU_DATA_W-1:0] op_a;
    logic [`EXU_DATA_W-1:0] op_b;
    logic [4:0]             shamt;
    logic [`EXU_DATA_W-1:0] res;

    assign op_a  = i_rs1_data;
    // Immediate form replaces rs2.
    assign op_b  = i_instr.use_imm ? i_instr.imm : i_rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_instr.op)
            exu_pkg::OP_ADD: begin
                res = op_a + op_b;
            end
            exu_pkg::OP_SUB: begin
                res = op_a - op_b;
            end
            exu_pkg::OP_AND: begin
                res = op_a & op_b;
            end
            exu_pkg::OP_OR: begin
                res = op_a | op_b;
            end
            exu_pkg::OP_XOR: begin
                res = op_a ^ op_b;
            end
            exu_pkg::OP_SLL: begin
                res = op_a << shamt;
            end
            exu_pkg::OP_SRL: begin
                res = op_a >> shamt;
            end
            exu_pkg::OP_SRA: begin
                res = $unsigned($signed(op_a) >>> shamt);
            end
            exu_pkg::OP_SLT: begin
                res = {{(`EXU_DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            exu_pkg::OP_SLTU: begin
                res = {{(`EXU_DATA_W-1){1'b0}}, op_a < op_b};
            end
            exu_pkg::OP_LUI: begin
                // Immediate arrives already shifted.
                res = i_instr.imm;
            end
            default: begin
                res = '0;
            end
        endcase
    end

    assign o_result.rd   = i_instr.rd;
    assign o_result.data = res;

endmodule

`default_nettype wire

// File: exu_regfile.sv
// Integer register file, two combinational reads and one write.
// x0 is hardwired to zero.

`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_regfile (
    input  wire                         aclk,
    input  wire                         aresetn,
    input  wire  [`EXU_REG_W-1:0]       i_rs1,
    input  wire  [`EXU_REG_W-1:0]       i_rs2,
    output logic [`EXU_DATA_W-1:0]      o_rs1_data,
    output logic [`EXU_DATA_W-1:0]      o_rs2_data,
    input  wire                         i_we,
    input  wire  exu_pkg::wb_t          i_wb
);

    logic [`EXU_DATA_W-1:0] regs [`EXU_REG_NB];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < `EXU_REG_NB; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_wb.rd != '0) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // Reads bypass nothing; a write lands at the edge.
    always_comb begin
        if (i_rs1 == '0) begin
            o_rs1_data = '0;
        end else begin
            o_rs1_data = regs[i_rs1];
        end
    end

    always_comb begin
        if (i_rs2 == '0) begin
            o_rs2_data = '0;
        end else begin
            o_rs2_data = regs[i_rs2];
        end
    end

endmodule

`default_nettype wire

// File: exu_pipeline.sv
// Valid/ready register chain. A full slice stalls its upstream, so a full
// chain of depth N passes one beat per cycle only while downstream is ready.

`timescale 1ns/1ps
`default_nettype none

module exu_pipeline #(
    parameter int DATA_BUS_W  = 8,
    parameter int NB_PIPELINE = 1
) (
    input  wire                   aclk,
    input  wire                   aresetn,
    input  wire                   i_valid,
    output logic                  o_ready,
    input  wire  [DATA_BUS_W-1:0] i_data,
    output logic                  o_valid,
    input  wire                   i_ready,
    output logic [DATA_BUS_W-1:0] o_data
);

    generate
        if (NB_PIPELINE == 0) begin : g_bypass

            // No registers, straight through.
            assign o_valid = i_valid;
            assign o_data  = i_data;
            assign o_ready = i_ready;

        end else if (NB_PIPELINE == 1) begin : g_slice

            logic full;

            // Holding a beat the next stage has not taken.
            assign full    = o_valid & ~i_ready;
            assign o_ready = ~full;

            always_ff @(posedge aclk or negedge aresetn) begin
                if (!aresetn) begin
                    o_valid <= 1'b0;
                end else if (!full) begin
                    o_valid <= i_valid;
                end
            end

            always_ff @(posedge aclk) begin
                if (!full) begin
                    o_data <= i_data;
                end
            end

        end else begin : g_chain

            logic                  mid_valid;
            logic                  mid_ready;
            logic [DATA_BUS_W-1:0] mid_data;

            // Head slice.
            exu_pipeline #(
                .DATA_BUS_W  (DATA_BUS_W),
                .NB_PIPELINE (1)
            ) u_head (
                .aclk    (aclk),
                .aresetn (aresetn),
                .i_valid (i_valid),
                .o_ready (o_ready),
                .i_data  (i_data),
                .o_valid (mid_valid),
                .i_ready (mid_ready),
                .o_data  (mid_data)
            );

            // Remaining depth.
            exu_pipeline #(
                .DATA_BUS_W  (DATA_BUS_W),
                .NB_PIPELINE (NB_PIPELINE - 1)
            ) u_tail (
                .aclk    (aclk),
                .aresetn (aresetn),
                .i_valid (mid_valid),
                .o_ready (mid_ready),
                .i_data  (mid_data),
                .o_valid (o_valid),
                .i_ready (i_ready),
                .o_data  (o_data)
            );

        end
    endgenerate

endmodule

`default_nettype wire

// File: exu_pkg.sv
// Shared types for the execution unit. Field widths come from exu_defs.svh.

`default_nettype none

`include "exu_defs.svh"

package exu_pkg;

    // ALU operations, RV32I integer subset.
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_SLTU = 4'd9,
        OP_LUI  = 4'd10
    } alu_op_t;

    // Decoded instruction as presented at issue.
    typedef struct packed {
        alu_op_t                op;
        logic [`EXU_REG_W-1:0]  rd;
        logic [`EXU_REG_W-1:0]  rs1;
        logic [`EXU_REG_W-1:0]  rs2;
        logic                   use_imm;
        logic [`EXU_DATA_W-1:0] imm;
    } instr_t;

    // Result heading for the register file.
    typedef struct packed {
        logic [`EXU_REG_W-1:0]  rd;
        logic [`EXU_DATA_W-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

// File: exu_defs.svh
// Sizing for the execution unit. EXU_REG_W must be wide enough to index
// EXU_REG_NB registers; EXU_STAGES may be zero.

`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// Datapath width.
`define EXU_DATA_W 32

// Register file size and index width.
`define EXU_REG_NB 32
`define EXU_REG_W 5

// Slices between the ALU and writeback.
`define EXU_STAGES 3

`endif
